// File: hdl/glb_cfg.svh
// chain sizing macros; tile id width must cover the tile count and data width must be a multiple of 8
`ifndef GLB_CFG_SVH
`define GLB_CFG_SVH

// number of tile stages in the chain
`define GLB_NUM_TILES 4

// tile select field taken from the upper address bits
`define GLB_TILE_ID_WIDTH 2

// word address inside one bank
// 64 words
`define GLB_BANK_ADDR_WIDTH 6

// full word address seen by the processor
`define GLB_ADDR_WIDTH (`GLB_TILE_ID_WIDTH + `GLB_BANK_ADDR_WIDTH)

// data word width
// one strobe bit per byte lane
`define GLB_DATA_WIDTH 32

`endif

// File: hdl/glb_pkg.sv
// shared packet types for the tile chain; widths come from glb_cfg.svh on the include path
package glb_pkg;

    `include "glb_cfg.svh"

    // opcode carried in every eastbound packet
    // anything other than idle marks the packet valid
    typedef enum logic [1:0] {
        OP_IDLE  = 2'b00,
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10
    } pkt_op_e;

    // processor word address
    // upper bits select the tile
    typedef logic [`GLB_ADDR_WIDTH-1:0] addr_t;

    // word address inside one bank
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // data word
    typedef logic [`GLB_DATA_WIDTH-1:0] data_t;

    // byte lane write strobe
    typedef logic [`GLB_DATA_WIDTH/8-1:0] strb_t;

    // tile select field
    typedef logic [`GLB_TILE_ID_WIDTH-1:0] tile_id_t;

endpackage

// File: hdl/glb_bank.sv
// single-port bank with registered read; contents are undefined until written and there is no reset
`timescale 1ns/100ps

module glb_bank (
    input  logic                clk,
    input  logic                wr_en,
    input  logic                rd_en,
    input  glb_pkg::strb_t      strb,
    input  glb_pkg::bank_addr_t addr,
    input  glb_pkg::data_t      wr_data,
    output glb_pkg::data_t      rd_data
);
    import glb_pkg::*;

    `include "glb_cfg.svh"

    localparam int num_words = 1 << `GLB_BANK_ADDR_WIDTH;
    localparam int num_lanes = `GLB_DATA_WIDTH / 8;

    // storage array
    data_t mem [num_words];

    // byte lane write
    // lanes with strobe low keep their old value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < num_lanes; lane++) begin
                if (strb[lane]) begin
                    mem[addr][lane*8 +: 8] <= wr_data[lane*8 +: 8];
                end
            end
        end
    end

    // registered read
    // output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule

// File: hdl/glb_tile.sv
// one chain stage with one register each way; tile_id must be unique and below the tile count
`timescale 1ns/100ps

module glb_tile #(
    parameter glb_pkg::tile_id_t tile_id = '0
) (
    input  logic              clk,
    input  logic              reset,

    // eastbound packet from the west neighbour
    input  glb_pkg::pkt_op_e  w2e_in_op,
    input  glb_pkg::strb_t    w2e_in_strb,
    input  glb_pkg::addr_t    w2e_in_addr,
    input  glb_pkg::data_t    w2e_in_data,
    input  glb_pkg::data_t    w2e_in_rdrs_data,
    input  logic              w2e_in_rdrs_valid,

    // eastbound packet to the east neighbour
    output glb_pkg::pkt_op_e  w2e_out_op,
    output glb_pkg::strb_t    w2e_out_strb,
    output glb_pkg::addr_t    w2e_out_addr,
    output glb_pkg::data_t    w2e_out_data,
    output glb_pkg::data_t    w2e_out_rdrs_data,
    output logic              w2e_out_rdrs_valid,

    // westbound response
    input  glb_pkg::data_t    e2w_in_rd_data,
    input  logic              e2w_in_rd_data_valid,
    output glb_pkg::data_t    e2w_out_rd_data,
    output logic              e2w_out_rd_data_valid
);
    import glb_pkg::*;

    `include "glb_cfg.svh"

    tile_id_t   pkt_tile_id;
    bank_addr_t pkt_bank_addr;
    logic       tile_hit;
    logic       bank_wr_en;
    logic       bank_rd_en;
    data_t      bank_rd_data;
    logic       rd_hit_q;
    data_t      rdrs_data_q;
    logic       rdrs_valid_q;

    // address split
    assign pkt_tile_id   = w2e_in_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_ID_WIDTH];
    assign pkt_bank_addr = w2e_in_addr[`GLB_BANK_ADDR_WIDTH-1:0];
    assign tile_hit      = (pkt_tile_id == tile_id);

    // bank acts on the same edge that captures the packet
    assign bank_wr_en = tile_hit && (w2e_in_op == OP_WRITE);
    assign bank_rd_en = tile_hit && (w2e_in_op == OP_READ);

    glb_bank u_bank (
        .clk     (clk),
        .wr_en   (bank_wr_en),
        .rd_en   (bank_rd_en),
        .strb    (w2e_in_strb),
        .addr    (pkt_bank_addr),
        .wr_data (w2e_in_data),
        .rd_data (bank_rd_data)
    );

    // eastbound control
    always_ff @(posedge clk) begin
        if (reset) begin
            w2e_out_op   <= OP_IDLE;
            rd_hit_q     <= 1'b0;
            rdrs_valid_q <= 1'b0;
        end else begin
            w2e_out_op   <= w2e_in_op;
            rd_hit_q     <= bank_rd_en;
            rdrs_valid_q <= w2e_in_rdrs_valid;
        end
    end

    // eastbound payload
    always_ff @(posedge clk) begin
        w2e_out_strb <= w2e_in_strb;
        w2e_out_addr <= w2e_in_addr;
        w2e_out_data <= w2e_in_data;
        rdrs_data_q  <= w2e_in_rdrs_data;
    end

    // bank output is already registered
    // so it joins the packet here
    assign w2e_out_rdrs_data  = rd_hit_q ? bank_rd_data : rdrs_data_q;
    assign w2e_out_rdrs_valid = rd_hit_q ? 1'b1 : rdrs_valid_q;

    // westbound stage
    always_ff @(posedge clk) begin
        if (reset) begin
            e2w_out_rd_data_valid <= 1'b0;
        end else begin
            e2w_out_rd_data_valid <= e2w_in_rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        e2w_out_rd_data <= e2w_in_rd_data;
    end

endmodule

// File: hdl/glb_proc_start.sv
// processor entry point; no ready signal, so every request is launched the cycle after it is sampled
`timescale 1ns/100ps

module glb_proc_start (
    input  logic              clk,
    input  logic              reset,

    // processor side
    input  logic              proc_wr_en,
    input  glb_pkg::strb_t    proc_wr_strb,
    input  glb_pkg::addr_t    proc_wr_addr,
    input  glb_pkg::data_t    proc_wr_data,
    input  logic              proc_rd_en,
    input  glb_pkg::addr_t    proc_rd_addr,
    output glb_pkg::data_t    proc_rd_data,
    output logic              proc_rd_data_valid,

    // eastbound packet into tile 0
    output glb_pkg::pkt_op_e  w2e_op,
    output glb_pkg::strb_t    w2e_strb,
    output glb_pkg::addr_t    w2e_addr,
    output glb_pkg::data_t    w2e_data,
    output glb_pkg::data_t    w2e_rdrs_data,
    output logic              w2e_rdrs_valid,

    // westbound response out of tile 0
    input  glb_pkg::data_t    e2w_rd_data,
    input  logic              e2w_rd_data_valid
);
    import glb_pkg::*;

    pkt_op_e op_next;
    addr_t   addr_next;
    strb_t   strb_next;
    data_t   data_next;

    // write wins when both enables are high
    // read packets carry zero data and zero strobe
    always_comb begin
        op_next   = OP_IDLE;
        addr_next = proc_rd_addr;
        strb_next = '0;
        data_next = '0;
        if (proc_wr_en) begin
            op_next   = OP_WRITE;
            addr_next = proc_wr_addr;
            strb_next = proc_wr_strb;
            data_next = proc_wr_data;
        end else if (proc_rd_en) begin
            op_next   = OP_READ;
        end
    end

    // launch register
    // opcode is the only control bit
    always_ff @(posedge clk) begin
        if (reset) begin
            w2e_op <= OP_IDLE;
        end else begin
            w2e_op <= op_next;
        end
    end

    always_ff @(posedge clk) begin
        w2e_strb <= strb_next;
        w2e_addr <= addr_next;
        w2e_data <= data_next;
    end

    // response slot starts empty
    // the addressed tile fills it
    assign w2e_rdrs_data  = '0;
    assign w2e_rdrs_valid = 1'b0;

    // returning read data
    always_ff @(posedge clk) begin
        if (reset) begin
            proc_rd_data_valid <= 1'b0;
        end else begin
            proc_rd_data_valid <= e2w_rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        proc_rd_data <= e2w_rd_data;
    end

endmodule

// File: hdl/glb_chain.sv
// chain top; read latency is fixed at 2*GLB_NUM_TILES+1 cycles and there is no back-pressure
`timescale 1ns/100ps

module glb_chain (
    input  logic              clk,
    input  logic              reset,
    input  logic              proc_wr_en,
    input  glb_pkg::strb_t    proc_wr_strb,
    input  glb_pkg::addr_t    proc_wr_addr,
    input  glb_pkg::data_t    proc_wr_data,
    input  logic              proc_rd_en,
    input  glb_pkg::addr_t    proc_rd_addr,
    output glb_pkg::data_t    proc_rd_data,
    output logic              proc_rd_data_valid
);
    import glb_pkg::*;

    `include "glb_cfg.svh"

    // index k feeds tile k
    // last index leaves the east end
    pkt_op_e w2e_op         [`GLB_NUM_TILES+1];
    strb_t   w2e_strb       [`GLB_NUM_TILES+1];
    addr_t   w2e_addr       [`GLB_NUM_TILES+1];
    data_t   w2e_data       [`GLB_NUM_TILES+1];
    data_t   w2e_rdrs_data  [`GLB_NUM_TILES+1];
    logic    w2e_rdrs_valid [`GLB_NUM_TILES+1];

    // index k leaves tile k westward
    // last index is the turnaround
    data_t   e2w_rd_data       [`GLB_NUM_TILES+1];
    logic    e2w_rd_data_valid [`GLB_NUM_TILES+1];

    glb_proc_start u_proc_start (
        .clk                (clk),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .w2e_op             (w2e_op[0]),
        .w2e_strb           (w2e_strb[0]),
        .w2e_addr           (w2e_addr[0]),
        .w2e_data           (w2e_data[0]),
        .w2e_rdrs_data      (w2e_rdrs_data[0]),
        .w2e_rdrs_valid     (w2e_rdrs_valid[0]),
        .e2w_rd_data        (e2w_rd_data[0]),
        .e2w_rd_data_valid  (e2w_rd_data_valid[0])
    );

    // east end turnaround
    assign e2w_rd_data[`GLB_NUM_TILES]       = w2e_rdrs_data[`GLB_NUM_TILES];
    assign e2w_rd_data_valid[`GLB_NUM_TILES] = w2e_rdrs_valid[`GLB_NUM_TILES];

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .tile_id (tile_id_t'(i))
        ) u_tile (
            .clk                   (clk),
            .reset                 (reset),
            .w2e_in_op             (w2e_op[i]),
            .w2e_in_strb           (w2e_strb[i]),
            .w2e_in_addr           (w2e_addr[i]),
            .w2e_in_data           (w2e_data[i]),
            .w2e_in_rdrs_data      (w2e_rdrs_data[i]),
            .w2e_in_rdrs_valid     (w2e_rdrs_valid[i]),
            .w2e_out_op            (w2e_op[i+1]),
            .w2e_out_strb          (w2e_strb[i+1]),
            .w2e_out_addr          (w2e_addr[i+1]),
            .w2e_out_data          (w2e_data[i+1]),
            .w2e_out_rdrs_data     (w2e_rdrs_data[i+1]),
            .w2e_out_rdrs_valid    (w2e_rdrs_valid[i+1]),
            .e2w_in_rd_data        (e2w_rd_data[i+1]),
            .e2w_in_rd_data_valid  (e2w_rd_data_valid[i+1]),
            .e2w_out_rd_data       (e2w_rd_data[i]),
            .e2w_out_rd_data_valid (e2w_rd_data_valid[i])
        );
    end

endmodule

// File: verif/glb_chain_tb.sv
// trace driven test of the tile chain; run from the project root so the trace path resolves
`timescale 1ns/100ps

module glb_chain_tb;
    import glb_pkg::*;

    `include "glb_cfg.svh"

    localparam int rd_latency = 2 * `GLB_NUM_TILES + 1;

    logic  clk = 1'b0;
    logic  reset = 1'b1;
    logic  proc_wr_en = 1'b0;
    strb_t proc_wr_strb = '0;
    addr_t proc_wr_addr = '0;
    data_t proc_wr_data = '0;
    logic  proc_rd_en = 1'b0;
    addr_t proc_rd_addr = '0;
    data_t proc_rd_data;
    logic  proc_rd_data_valid;

    // trace columns
    // one entry per request line
    string tr_name [$];
    string tr_op [$];
    strb_t tr_strb [$];
    addr_t tr_addr [$];
    data_t tr_data [$];
    data_t tr_exp [$];
    int    tr_b2b [$];
    int    tr_gap [$];

    // outstanding reads
    // oldest first
    string exp_name_q [$];
    data_t exp_data_q [$];
    int    exp_issue_q [$];

    // byte lane reference model of the whole address space
    data_t model_mem [1 << `GLB_ADDR_WIDTH];
    bit    model_set [1 << `GLB_ADDR_WIDTH];

    int cycle = 0;
    int limit = 0;
    int seed = 92174;

    glb_chain uut (
        .clk                (clk),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_rd_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s latency: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // new bytes only where the strobe bit is set
    function automatic data_t merge_lanes(input data_t old, input data_t new_data,
                                          input strb_t strb);
        data_t res;
        res = old;
        for (int lane = 0; lane < `GLB_DATA_WIDTH / 8; lane++) begin
            if (strb[lane]) begin
                res[lane*8 +: 8] = new_data[lane*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic load_trace();
        int    fd;
        int    rc;
        string tok;
        string rest;
        string op;
        strb_t strb;
        addr_t addr;
        data_t data;
        data_t exp;
        int    b2b;
        fd = $fopen("verif/glb_chain_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verif/glb_chain_trace.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", tok);
            if (rc == 1 && tok.substr(0, 0) == "#") begin
                rc = $fgets(rest, fd);
            end else if (rc == 1) begin
                rc = $fscanf(fd, "%s %h %h %h %h %d", op, strb, addr, data, exp, b2b);
                if (rc != 6) begin
                    $display("trace line %s is missing columns", tok);
                    abort_run();
                end
                tr_name.push_back(tok);
                tr_op.push_back(op);
                tr_strb.push_back(strb);
                tr_addr.push_back(addr);
                tr_data.push_back(data);
                tr_exp.push_back(exp);
                tr_b2b.push_back(b2b);
            end
        end
        $fclose(fd);
    endtask

    // one cycle with both enables low
    task automatic drive_idle();
        @(posedge clk);
        #1;
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
    endtask

    task automatic drive_request(input int i);
        @(posedge clk);
        #1;
        proc_wr_en = (tr_op[i] == "W") || (tr_op[i] == "B");
        proc_rd_en = (tr_op[i] == "R") || (tr_op[i] == "B");
        proc_wr_strb = tr_strb[i];
        proc_wr_addr = tr_addr[i];
        proc_wr_data = tr_data[i];
        proc_rd_addr = tr_addr[i];
        // the address port not in use points at another tile and word
        if (tr_op[i] == "R") begin
            proc_wr_addr = ~tr_addr[i];
        end else begin
            proc_rd_addr = ~tr_addr[i];
        end
        // the dropped read of a B line expects nothing
        if (tr_op[i] == "R") begin
            exp_name_q.push_back(tr_name[i]);
            exp_data_q.push_back(tr_exp[i]);
            exp_issue_q.push_back(cycle + 1);
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("timeout after %0d cycles with %0d reads outstanding", cycle,
                     exp_name_q.size());
            abort_run();
        end
    end

    // mid cycle sample
    // away from the edge that updates the outputs
    always @(negedge clk) begin : rd_monitor
        string name;
        data_t exp;
        int    issued;
        if (proc_rd_data_valid === 1'b1) begin
            if (exp_name_q.size() == 0) begin
                $display("read data valid at cycle %0d with no read outstanding", cycle);
                abort_run();
            end else begin
                name = exp_name_q.pop_front();
                exp = exp_data_q.pop_front();
                issued = exp_issue_q.pop_front();
                check_rd_data(name, exp, proc_rd_data);
                check_latency(name, rd_latency, cycle - issued);
            end
        end
    end

    initial begin : run
        int idle_total;
        int gap;
        load_trace();
        idle_total = 0;
        // gaps and the trace's own expected words are settled before time moves
        for (int i = 0; i < tr_name.size(); i++) begin
            gap = (tr_b2b[i] != 0) ? 0 : int'($unsigned($random(seed)) % 4);
            tr_gap.push_back(gap);
            idle_total = idle_total + gap;
            if (tr_op[i] == "W" || tr_op[i] == "B") begin
                model_mem[tr_addr[i]] = merge_lanes(model_mem[tr_addr[i]], tr_data[i],
                                                    tr_strb[i]);
                model_set[tr_addr[i]] = 1'b1;
            end else if (tr_op[i] == "R") begin
                if (!model_set[tr_addr[i]]) begin
                    $display("trace line %s reads an address never written", tr_name[i]);
                    abort_run();
                end
                check_rd_data({tr_name[i], " model"}, model_mem[tr_addr[i]], tr_exp[i]);
            end else begin
                $display("trace line %s has an unknown opcode %s", tr_name[i], tr_op[i]);
                abort_run();
            end
        end
        limit = 4 * (tr_name.size() + idle_total) + 2 * `GLB_NUM_TILES + 10;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < tr_name.size(); i++) begin
            repeat (tr_gap[i]) drive_idle();
            drive_request(i);
        end
        drive_idle();

        while (exp_name_q.size() != 0) begin
            @(posedge clk);
        end
        // long enough for a stray valid from a dropped read to show up
        repeat (rd_latency + 1) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: glb_chain.f
+incdir+hdl
hdl/glb_pkg.sv
hdl/glb_bank.sv
hdl/glb_tile.sv
hdl/glb_proc_start.sv
hdl/glb_chain.sv
verif/glb_chain_tb.sv

// File: Makefile
# Verilator build and run for the glb_chain testbench
SIM      ?= verilator
TOP      ?= glb_chain_tb
FILELIST ?= glb_chain.f
BUILD    ?= obj_dir
VFLAGS   ?= --binary --timing -j 0
PASS_MSG ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(SIM) and run $(TOP), fails unless the pass line is printed"
	@echo "  clean  remove $(BUILD)"
	@echo "variables: SIM TOP FILELIST BUILD VFLAGS PASS_MSG"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	@out="$$(./$(BUILD)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: verif/glb_chain_trace.txt
# name op strb addr data expected b2b (hex except b2b)
# op W write, R read, B write and read together; b2b 1 issues with no idle gap before
t0_wr      W f 05 11223344 00000000 0
t0_rd      R 0 05 00000000 11223344 0
t1_wr      W f 4a a5a5a5a5 00000000 0
t1_rd      R 0 4a 00000000 a5a5a5a5 0
t2_wr      W f 93 deadbeef 00000000 0
t2_rd      R 0 93 00000000 deadbeef 0
t3_wr      W f ff 01020304 00000000 0
t3_rd      R 0 ff 00000000 01020304 0
mrg_full   W f 10 cafef00d 00000000 0
mrg_part   W 5 10 12345678 00000000 0
mrg_rd     R 0 10 00000000 ca34f078 0
mrg_top    W 8 10 99000000 00000000 0
mrg_rd2    R 0 10 00000000 9934f078 0
mid_full   W f 80 ffffffff 00000000 0
mid_part   W 6 80 00000000 00000000 0
mid_rd     R 0 80 00000000 ff0000ff 1
b2b_rd0    R 0 05 00000000 11223344 0
b2b_rd1    R 0 4a 00000000 a5a5a5a5 1
b2b_rd2    R 0 93 00000000 deadbeef 1
b2b_rd3    R 0 ff 00000000 01020304 1
raw_wr2    W f 93 0badc0de 00000000 0
raw_rd2    R 0 93 00000000 0badc0de 1
raw_wr3    W 3 ff 0000aabb 00000000 0
raw_rd3    R 0 ff 00000000 0102aabb 1
both_t1    B f 4a 77665544 00000000 0
both_chk   R 0 4a 00000000 77665544 0
t0_again   R 0 05 00000000 11223344 1
